//--- verilog/jpeg_rle_pkg.sv
package jpeg_rle_pkg;

	// Quantized coefficient in two's complement.
	typedef logic signed [11:0] coef_t;

	typedef logic [3:0] size_t;
	typedef logic [3:0] run_t;
	typedef logic [11:0] amp_t;

	// Zigzag index within an 8x8 block.
	typedef logic [5:0] pos_t;

	// One run-length symbol. eob is set only on the end-of-block symbol.
	typedef struct packed
	{
		logic  dc;
		logic  eob;
		run_t  run;
		size_t size;
		amp_t  amp;
	} rle_sym_t;

	localparam run_t ZRL_RUN = 4'd15;

	// Sixteen zeros.
	localparam rle_sym_t ZRL_SYM = '{dc: 1'b0, eob: 1'b0, run: ZRL_RUN, size: 4'd0,
		amp: 12'd0};

	// End of block with run 0 and size 0.
	localparam rle_sym_t EOB_SYM = '{dc: 1'b0, eob: 1'b1, run: 4'd0, size: 4'd0,
		amp: 12'd0};

endpackage

//--- verilog/jpeg_bus_pkg.sv
package jpeg_bus_pkg;

	// Wishbone classic request from master to slave.
	typedef struct packed
	{
		logic [3:0]  adr;
		logic [31:0] dat;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// Slave to master.
	typedef struct packed
	{
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// Word addresses.
	localparam logic [3:0] ADR_COEF   = 4'd0;
	localparam logic [3:0] ADR_SYM    = 4'd1;
	localparam logic [3:0] ADR_STATUS = 4'd2;

endpackage

//--- verilog/jpeg_size_cat.sv
`timescale 1ns/1ps

module jpeg_size_cat
(
	input  jpeg_rle_pkg::coef_t coef,
	output jpeg_rle_pkg::size_t size,
	output jpeg_rle_pkg::amp_t  amp
);

	logic [11:0] mag;
	logic [12:0] mask;

	// Magnitude. -2048 comes out as 12'h800.
	assign mag = coef[11] ? 12'(-coef) : 12'(coef);

	// Bit length of the magnitude.
	always_comb
	begin
		size = '0;
		for (int i = 0; i < 12; i++)
		begin
			if (mag[i])
				size = jpeg_rle_pkg::size_t'(i + 1);
		end
	end

	assign mask = (13'd1 << size) - 13'd1;

	// Negative values send coef - 1 truncated to size bits.
	assign amp = coef[11] ? jpeg_rle_pkg::amp_t'(coef - 12'sd1) & mask[11:0] : coef;

endmodule

//--- verilog/jpeg_run_counter.sv
`timescale 1ns/1ps

module jpeg_run_counter
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   coef_valid,
	input  jpeg_rle_pkg::coef_t    coef,
	output logic                   coef_ready,
	output logic                   raw_valid,
	output jpeg_rle_pkg::rle_sym_t raw_sym,
	input  logic                   raw_ready,
	output jpeg_rle_pkg::pos_t     pos
);

	typedef enum logic [1:0] {st_idle, st_emit, st_emit_eob} state_t;

	state_t                 state;
	jpeg_rle_pkg::run_t     run;
	logic                   eob_owed;
	jpeg_rle_pkg::size_t    size;
	jpeg_rle_pkg::amp_t     amp;
	jpeg_rle_pkg::rle_sym_t new_sym;
	logic                   make_sym;
	logic                   owe_eob;
	logic                   clear_run;
	logic                   accept;

	jpeg_size_cat u_size_cat
	(
		.coef (coef),
		.size (size),
		.amp  (amp)
	);

	assign raw_valid  = (state != st_idle);
	// Held off while an EOB is still owed after a ZRL at position 63.
	assign coef_ready = (state == st_idle) || (raw_ready && !eob_owed);
	assign accept     = coef_valid && coef_ready;

	////////////////////////////////////////
	// Symbol decode for the incoming coefficient.
	////////////////////////////////////////

	always_comb
	begin
		new_sym   = '{dc: 1'b0, eob: 1'b0, run: run, size: size, amp: amp};
		make_sym  = 1'b1;
		owe_eob   = 1'b0;
		clear_run = 1'b1;
		if (pos == '0)
		begin
			new_sym.dc  = 1'b1;
			new_sym.run = '0;
		end
		else if (coef == '0)
		begin
			if (run == jpeg_rle_pkg::ZRL_RUN)
			begin
				// Sixteenth zero.
				new_sym = jpeg_rle_pkg::ZRL_SYM;
				owe_eob = (pos == '1);
			end
			else if (pos == '1)
				new_sym = jpeg_rle_pkg::EOB_SYM;
			else
			begin
				make_sym  = 1'b0;
				clear_run = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Position, run and output state.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state    <= st_idle;
			pos      <= '0;
			run      <= '0;
			eob_owed <= 1'b0;
		end
		else if (accept)
		begin
			pos      <= pos + 1'b1;
			run      <= clear_run ? '0 : run + 1'b1;
			eob_owed <= owe_eob;
			state    <= make_sym ? st_emit : st_idle;
		end
		else if (raw_valid && raw_ready)
		begin
			eob_owed <= 1'b0;
			state    <= eob_owed ? st_emit_eob : st_idle;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && make_sym)
			raw_sym <= new_sym;
		else if (raw_valid && raw_ready && eob_owed)
			raw_sym <= jpeg_rle_pkg::EOB_SYM;
	end

endmodule

//--- verilog/jpeg_rzs.sv
`timescale 1ns/1ps

module jpeg_rzs
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   raw_valid,
	input  jpeg_rle_pkg::rle_sym_t raw_sym,
	output logic                   raw_ready,
	output logic                   out_valid,
	output jpeg_rle_pkg::rle_sym_t out_sym,
	input  logic                   out_ready
);

	typedef enum logic {st_pass, st_release} state_t;

	state_t                 state;
	logic [1:0]             pending;
	jpeg_rle_pkg::rle_sym_t hold_sym;
	logic                   slot_free;
	logic                   take;
	logic                   is_zrl;
	logic                   pass_now;

	assign slot_free = !out_valid || out_ready;
	assign raw_ready = (state == st_pass) && slot_free;
	assign take      = raw_valid && raw_ready;
	assign is_zrl    = (raw_sym.run == jpeg_rle_pkg::ZRL_RUN) && (raw_sym.size == '0);

	// EOB drops whatever ZRLs are pending.
	assign pass_now = raw_sym.eob || (pending == '0);

	////////////////////////////////////////
	// Pending ZRL count and output valid.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state     <= st_pass;
			pending   <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			case (state)
				st_pass:
				begin
					if (take)
					begin
						if (is_zrl)
						begin
							pending   <= pending + 1'b1;
							out_valid <= 1'b0;
						end
						else if (pass_now)
						begin
							pending   <= '0;
							out_valid <= 1'b1;
						end
						else
						begin
							// First held ZRL goes out now.
							pending   <= pending - 1'b1;
							out_valid <= 1'b1;
							state     <= st_release;
						end
					end
					else if (out_ready)
						out_valid <= 1'b0;
				end
				st_release:
				begin
					if (out_ready)
					begin
						if (pending == '0)
							state <= st_pass;
						else
							pending <= pending - 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take && !is_zrl)
		begin
			hold_sym <= raw_sym;
			out_sym  <= pass_now ? raw_sym : jpeg_rle_pkg::ZRL_SYM;
		end
		else if (state == st_release && out_ready)
			out_sym <= (pending == '0) ? hold_sym : jpeg_rle_pkg::ZRL_SYM;
	end

endmodule

//--- verilog/jpeg_sym_fifo.sv
`timescale 1ns/1ps

module jpeg_sym_fifo
#(
	parameter int FIFO_DEPTH = 64,
	parameter int CNT_W      = $clog2(FIFO_DEPTH) + 1
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  jpeg_rle_pkg::rle_sym_t push_sym,
	output logic                   not_full,
	input  logic                   pop,
	output jpeg_rle_pkg::rle_sym_t head,
	output logic [CNT_W-1:0]       count
);

	localparam int AW = $clog2(FIFO_DEPTH);

	jpeg_rle_pkg::rle_sym_t mem [FIFO_DEPTH];
	logic [AW-1:0]          wr_ptr;
	logic [AW-1:0]          rd_ptr;
	logic                   do_push;
	logic                   do_pop;

	assign not_full = (count != CNT_W'(FIFO_DEPTH));
	assign do_push  = push && not_full;
	assign do_pop   = pop && (count != '0);
	assign head     = mem[rd_ptr];

	// Pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_sym;
	end

endmodule

//--- verilog/jpeg_wb_slave.sv
`timescale 1ns/1ps

module jpeg_wb_slave
#(
	parameter int FIFO_DEPTH = 64,
	parameter int CNT_W      = $clog2(FIFO_DEPTH) + 1
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  jpeg_bus_pkg::wb_req_t  wb_req,
	output jpeg_bus_pkg::wb_rsp_t  wb_rsp,
	output logic                   coef_valid,
	output jpeg_rle_pkg::coef_t    coef,
	input  logic                   coef_ready,
	output logic                   pop,
	input  jpeg_rle_pkg::rle_sym_t head,
	input  logic [CNT_W-1:0]       count,
	input  jpeg_rle_pkg::pos_t     pos
);

	logic        ack;
	logic [31:0] rd_dat;
	logic [31:0] rd_next;
	logic        start;
	logic        coef_wr;
	logic        sym_rd;

	// New transfer. The ack cycle and a pending coefficient block a restart.
	assign start   = wb_req.cyc && wb_req.stb && !ack && !coef_valid;
	assign coef_wr = start && wb_req.we && (wb_req.adr == jpeg_bus_pkg::ADR_COEF);
	assign sym_rd  = start && !wb_req.we && (wb_req.adr == jpeg_bus_pkg::ADR_SYM);
	assign pop     = sym_rd && (count != '0);

	////////////////////////////////////////
	// Read data mux.
	////////////////////////////////////////

	always_comb
	begin
		rd_next = '0;
		if (!wb_req.we)
		begin
			if (wb_req.adr == jpeg_bus_pkg::ADR_SYM && count != '0)
				rd_next = {1'b1, 9'b0, head.eob, head.dc, head.run, head.size, head.amp};
			else if (wb_req.adr == jpeg_bus_pkg::ADR_STATUS)
				rd_next = {10'b0, pos, 16'(count)};
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ack        <= 1'b0;
			coef_valid <= 1'b0;
		end
		else
		begin
			// Coefficient writes ack one cycle after the counter takes them.
			ack <= (start && !coef_wr) || (coef_valid && coef_ready);
			if (coef_wr)
				coef_valid <= 1'b1;
			else if (coef_ready)
				coef_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (coef_wr)
			coef <= jpeg_rle_pkg::coef_t'(wb_req.dat[11:0]);
		if (start)
			rd_dat <= rd_next;
	end

	assign wb_rsp = '{dat: rd_dat, ack: ack};

endmodule

//--- verilog/jpeg_rle_top.sv
`timescale 1ns/1ps

module jpeg_rle_top
#(
	parameter int FIFO_DEPTH = 64,
	parameter int CNT_W      = $clog2(FIFO_DEPTH) + 1
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  jpeg_bus_pkg::wb_req_t wb_req,
	output jpeg_bus_pkg::wb_rsp_t wb_rsp
);

	logic                   coef_valid;
	logic                   coef_ready;
	jpeg_rle_pkg::coef_t    coef;
	logic                   raw_valid;
	logic                   raw_ready;
	jpeg_rle_pkg::rle_sym_t raw_sym;
	logic                   out_valid;
	logic                   out_ready;
	jpeg_rle_pkg::rle_sym_t out_sym;
	logic                   pop;
	jpeg_rle_pkg::rle_sym_t head;
	logic [CNT_W-1:0]       count;
	jpeg_rle_pkg::pos_t     pos;

	jpeg_wb_slave #(.FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) u_wb_slave
	(
		.clk        (clk),
		.rst        (rst),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.coef_valid (coef_valid),
		.coef       (coef),
		.coef_ready (coef_ready),
		.pop        (pop),
		.head       (head),
		.count      (count),
		.pos        (pos)
	);

	jpeg_run_counter u_run_counter
	(
		.clk        (clk),
		.rst        (rst),
		.coef_valid (coef_valid),
		.coef       (coef),
		.coef_ready (coef_ready),
		.raw_valid  (raw_valid),
		.raw_sym    (raw_sym),
		.raw_ready  (raw_ready),
		.pos        (pos)
	);

	// ZRLs ahead of an EOB are dropped here.
	jpeg_rzs u_rzs
	(
		.clk       (clk),
		.rst       (rst),
		.raw_valid (raw_valid),
		.raw_sym   (raw_sym),
		.raw_ready (raw_ready),
		.out_valid (out_valid),
		.out_sym   (out_sym),
		.out_ready (out_ready)
	);

	jpeg_sym_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) u_sym_fifo
	(
		.clk      (clk),
		.rst      (rst),
		.push     (out_valid),
		.push_sym (out_sym),
		.not_full (out_ready),
		.pop      (pop),
		.head     (head),
		.count    (count)
	);

endmodule

//--- tb/jpeg_rle_assertions.sv
`timescale 1ns/1ps

module jpeg_rle_assertions
(
	input logic                   clk,
	input logic                   rst,
	input jpeg_bus_pkg::wb_req_t  wb_req,
	input jpeg_bus_pkg::wb_rsp_t  wb_rsp,
	input logic                   out_valid,
	input logic                   out_ready,
	input jpeg_rle_pkg::rle_sym_t out_sym
);

	logic last_zrl;
	logic out_fire;
	logic out_is_zrl;

	assign out_fire   = out_valid && out_ready;
	assign out_is_zrl = (out_sym.run == jpeg_rle_pkg::ZRL_RUN) && (out_sym.size == '0);

	// Last symbol pushed into the FIFO was a ZRL.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			last_zrl <= 1'b0;
		else if (out_fire)
			last_zrl <= out_is_zrl;
	end

	held_stable: assert property (@(posedge clk) disable iff (!rst)
		out_valid && !out_ready |=> out_valid && $stable(out_sym))
		else $error("rzs output changed while stalled");

	no_zrl_before_eob: assert property (@(posedge clk) disable iff (!rst)
		out_fire && out_sym.eob |-> !last_zrl)
		else $error("ZRL directly ahead of EOB at rzs output");

	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
		else $error("ack outside of a bus cycle");

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack held for two cycles");

endmodule

// Bus port and rzs output checks.
bind jpeg_rle_top jpeg_rle_assertions u_assertions
(
	.clk       (clk),
	.rst       (rst),
	.wb_req    (wb_req),
	.wb_rsp    (wb_rsp),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_sym   (out_sym)
);

//--- tb/jpeg_rle_tb.sv
`timescale 1ns/1ps

module jpeg_rle_tb;

	localparam int FIFO_DEPTH  = 64;
	localparam int ACK_TIMEOUT = 200;
	localparam int POLL_LIMIT  = 500;

	// Test block with up to eight nonzero entries and the rest zero.
	typedef struct packed
	{
		logic             read_after;
		logic [3:0]       n;
		logic [7:0][5:0]  pos;
		logic [7:0][11:0] val;
	} row_t;

	logic                  clk;
	logic                  rst;
	jpeg_bus_pkg::wb_req_t wb_req;
	jpeg_bus_pkg::wb_rsp_t wb_rsp;

	row_t                   rows [$];
	row_t                   cur;
	jpeg_rle_pkg::coef_t    blk [64];
	jpeg_rle_pkg::rle_sym_t exp_q [$];
	logic [31:0]            rng;
	int                     mismatches;
	int                     timeouts;

	jpeg_rle_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT
	(
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// Reference model.
	////////////////////////////////////////

	function automatic jpeg_rle_pkg::rle_sym_t make_sym(input logic dc, input logic eob,
		input int run, input int v);
		jpeg_rle_pkg::rle_sym_t s;
		int m;
		int bits;
		m = (v < 0) ? -v : v;
		bits = 0;
		while (m > 0)
		begin
			bits++;
			m = m >> 1;
		end
		s.dc   = dc;
		s.eob  = eob;
		s.run  = 4'(run);
		s.size = 4'(bits);
		// Negative amplitude is v - 1 in the low size bits.
		s.amp  = (v < 0) ? 12'((v - 1) & ((1 << bits) - 1)) : 12'(v);
		return s;
	endfunction

	task automatic build_expected();
		int run;
		int zrl;
		int v;
		run = 0;
		zrl = 0;
		for (int i = 0; i < 64; i++)
		begin
			v = int'(blk[i]);
			if (i == 0)
				exp_q.push_back(make_sym(1'b1, 1'b0, 0, v));
			else if (v != 0)
			begin
				repeat (zrl) exp_q.push_back(make_sym(1'b0, 1'b0, 15, 0));
				zrl = 0;
				exp_q.push_back(make_sym(1'b0, 1'b0, run, v));
				run = 0;
			end
			else
			begin
				run++;
				if (run == 16)
				begin
					zrl++;
					run = 0;
				end
				// Trailing ZRLs vanish with the EOB.
				if (i == 63)
				begin
					zrl = 0;
					exp_q.push_back(make_sym(1'b0, 1'b1, 0, 0));
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Bus tasks.
	////////////////////////////////////////

	task automatic bus_cycle(input logic [3:0] adr, input logic we, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int t;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		wb_req.we  = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			#1;
			t++;
		end
		while (!wb_rsp.ack && t < ACK_TIMEOUT);
		rdat = wb_rsp.dat;
		if (!wb_rsp.ack)
		begin
			$display("Timeout at %0t: no ack for access to address %0d", $time, adr);
			timeouts++;
		end
		// Hold the request through the ack cycle.
		@(posedge clk);
		#1;
		wb_req = '0;
	endtask

	task automatic bus_read(input logic [3:0] adr, output logic [31:0] rdat);
		bus_cycle(adr, 1'b0, 32'd0, rdat);
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_cycle(adr, 1'b1, wdat, unused);
	endtask

	////////////////////////////////////////
	// Stimulus table.
	////////////////////////////////////////

	task automatic add_nz(input int p, input int v);
		cur.pos[cur.n] = 6'(p);
		cur.val[cur.n] = 12'(v);
		cur.n = cur.n + 1'b1;
	endtask

	task automatic push_row(input logic read_after);
		cur.read_after = read_after;
		rows.push_back(cur);
		cur = '0;
	endtask

	task automatic build_table();
		logic [31:0] r;
		int v;
		cur = '0;
		// DC only.
		add_nz(0, 37);
		push_row(1);
		add_nz(0, -300);
		push_row(1);
		// Mixed signs and sizes.
		add_nz(0, -7);
		add_nz(1, 1);
		add_nz(2, -1);
		add_nz(5, 3);
		add_nz(6, -4);
		add_nz(12, 255);
		add_nz(13, -256);
		add_nz(40, 2047);
		push_row(1);
		add_nz(1, -2047);
		add_nz(2, 1024);
		add_nz(3, -2048);
		push_row(1);
		// Runs of sixteen and more.
		add_nz(0, 1);
		add_nz(17, 5);
		push_row(1);
		add_nz(0, 1);
		add_nz(40, -3);
		push_row(1);
		add_nz(0, 2);
		add_nz(49, 9);
		add_nz(63, -1);
		push_row(1);
		// Suppressed ZRLs ahead of EOB.
		add_nz(0, 3);
		add_nz(1, 4);
		push_row(1);
		add_nz(47, 6);
		push_row(1);
		push_row(1);
		// 6 + 6 * 10 symbols fill the FIFO and the two stages ahead of it.
		add_nz(0, 11);
		add_nz(12, 1);
		add_nz(24, -2);
		add_nz(36, 3);
		add_nz(48, -4);
		push_row(0);
		for (int b = 1; b <= 6; b++)
		begin
			for (int k = 0; k < 8; k++)
				add_nz(7 * (k + 1), (k % 2) ? -(b * 10 + k + 1) : (b * 10 + k + 1));
			push_row(b == 6);
		end
		// Sparse random blocks.
		for (int i = 0; i < 24; i++)
		begin
			rng = xorshift(rng);
			r = rng;
			for (int k = 0; k <= int'(r[2:0]); k++)
			begin
				rng = xorshift(rng);
				v = int'($signed(rng[11:0]));
				if (v == 0)
					v = 1;
				add_nz(int'(rng[21:16]), v);
			end
			push_row(i % 3 != 0);
		end
	endtask

	////////////////////////////////////////
	// Block write and symbol drain.
	////////////////////////////////////////

	task automatic write_block(input row_t row);
		for (int i = 0; i < 64; i++)
			blk[i] = '0;
		for (int k = 0; k < int'(row.n); k++)
			blk[row.pos[k]] = jpeg_rle_pkg::coef_t'(row.val[k]);
		build_expected();
		for (int i = 0; i < 64; i++)
			bus_write(jpeg_bus_pkg::ADR_COEF, {20'd0, blk[i]});
	endtask

	task automatic check_full();
		logic [31:0] d;
		bus_read(jpeg_bus_pkg::ADR_STATUS, d);
		if (d[15:0] != 16'(FIFO_DEPTH) || d[21:16] != 6'd0)
		begin
			$display("FAIL %0t: status %h, expected full FIFO at position 0", $time, d);
			mismatches++;
		end
	endtask

	task automatic drain_and_check();
		logic [31:0] d;
		logic [31:0] want;
		jpeg_rle_pkg::rle_sym_t s;
		int got;
		int polls;
		got = 0;
		polls = 0;
		while (got < exp_q.size() && polls < POLL_LIMIT)
		begin
			bus_read(jpeg_bus_pkg::ADR_SYM, d);
			polls++;
			if (d[31])
			begin
				s = exp_q[got];
				want = {1'b1, 9'd0, s.eob, s.dc, s.run, s.size, s.amp};
				if (d != want)
				begin
					$display("FAIL %0t: symbol %0d read %h, expected %h", $time, got, d, want);
					mismatches++;
				end
				got++;
			end
		end
		if (got < exp_q.size())
		begin
			$display("Timeout at %0t: only %0d of %0d symbols arrived", $time, got,
				exp_q.size());
			timeouts++;
		end
		exp_q.delete();
		// Nothing beyond the expected symbols.
		bus_read(jpeg_bus_pkg::ADR_SYM, d);
		if (d != 32'd0)
		begin
			$display("FAIL %0t: read of empty FIFO returned %h", $time, d);
			mismatches++;
		end
	endtask

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b0;
		wb_req     = '0;
		rng        = 32'hf0451686;
		mismatches = 0;
		timeouts   = 0;
		build_table();
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b1;
		@(posedge clk);
		#1;
		for (int r = 0; r < rows.size(); r++)
		begin
			write_block(rows[r]);
			if (rows[r].read_after)
			begin
				if (exp_q.size() > FIFO_DEPTH)
					check_full();
				drain_and_check();
			end
		end
		$display("Summary: %0d rows, %0d mismatches, %0d timeouts", rows.size(), mismatches,
			timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- jpeg_rle_top.f
verilog/jpeg_rle_pkg.sv
verilog/jpeg_bus_pkg.sv
verilog/jpeg_size_cat.sv
verilog/jpeg_run_counter.sv
verilog/jpeg_rzs.sv
verilog/jpeg_sym_fifo.sv
verilog/jpeg_wb_slave.sv
verilog/jpeg_rle_top.sv
tb/jpeg_rle_assertions.sv
tb/jpeg_rle_tb.sv
